// ==== src/clock_pkg.sv ====
package clock_pkg;

    // ====================================================================
    // configuration bus
    // ====================================================================
    localparam int DATA_W = 8;
    localparam int ADDR_W = 2;

    localparam logic [ADDR_W-1:0] ADDR_CTRL   = 2'd0;
    localparam logic [ADDR_W-1:0] ADDR_DIVIDE = 2'd1;
    localparam logic [ADDR_W-1:0] ADDR_STATUS = 2'd2;  // read only and cleared by a write

    localparam int CTRL_RUN_BIT = 0;
    localparam int CTRL_BOP_BIT = 1;

    localparam int CNT_W        = 7;  // major-cycle count in status 6:0
    localparam int STAT_ERR_BIT = 7;

    // ====================================================================
    // phase state codes in stepping order
    // ====================================================================
    localparam logic [1:0] PH_W = 2'b00;
    localparam logic [1:0] PH_X = 2'b01;
    localparam logic [1:0] PH_Y = 2'b11;
    localparam logic [1:0] PH_Z = 2'b10;

endpackage

// ==== src/clock_config.sv ====
`timescale 1ns/1ps

module clock_config #(
    parameter int DIV_W = 4
) (
    input  logic                             sim_clk,
    input  logic                             arst_n,
    input  logic                             cfg_we,
    input  logic [clock_pkg::ADDR_W-1:0]     cfg_addr,
    input  logic [clock_pkg::DATA_W-1:0]     cfg_wdata,
    input  logic [clock_pkg::CNT_W-1:0]      cycle_count,
    input  logic                             overlap_err,
    output logic [clock_pkg::DATA_W-1:0]     cfg_rdata,
    output logic                             run,
    output logic                             bop,
    output logic [DIV_W-1:0]                 divide,
    output logic                             cnt_clear
);

    // ====================================================================
    // register writes
    // ====================================================================
    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            run    <= 1'b0;
            bop    <= 1'b0;
            divide <= '0;
        end else if (cfg_we) begin
            case (cfg_addr)
                clock_pkg::ADDR_CTRL: begin
                    run <= cfg_wdata[clock_pkg::CTRL_RUN_BIT];
                    bop <= cfg_wdata[clock_pkg::CTRL_BOP_BIT];
                end
                clock_pkg::ADDR_DIVIDE: begin
                    divide <= cfg_wdata[DIV_W-1:0];
                end
                default: begin
                end
            endcase
        end
    end

    // status write clears the monitor at the same edge
    assign cnt_clear = cfg_we && (cfg_addr == clock_pkg::ADDR_STATUS);

    // ====================================================================
    // readback
    // ====================================================================
    always_comb begin
        cfg_rdata = '0;
        case (cfg_addr)
            clock_pkg::ADDR_CTRL: begin
                cfg_rdata[clock_pkg::CTRL_RUN_BIT] = run;
                cfg_rdata[clock_pkg::CTRL_BOP_BIT] = bop;
            end
            clock_pkg::ADDR_DIVIDE: begin
                cfg_rdata[DIV_W-1:0] = divide;  // zero extended
            end
            clock_pkg::ADDR_STATUS: begin
                cfg_rdata[clock_pkg::CNT_W-1:0]     = cycle_count;
                cfg_rdata[clock_pkg::STAT_ERR_BIT] = overlap_err;
            end
            default: begin
            end
        endcase
    end

    // the monitor sees a single clear per status write
    a_clear_single: assert property (
        @(posedge sim_clk) disable iff (!arst_n)
        cnt_clear |=> !cnt_clear
    );

endmodule

// ==== src/phase_counter.sv ====
`timescale 1ns/1ps

module phase_counter #(
    parameter int DIV_W = 4
) (
    input  logic             sim_clk,
    input  logic             arst_n,
    input  logic             run,
    input  logic             bop,
    input  logic [DIV_W-1:0] divide,
    output logic             cgpp,
    output logic             cgppn,
    output logic             cgqp,
    output logic             cgqpn,
    output logic             cgrp,
    output logic             cgrpn,
    output logic             phase_valid
);

    logic [1:0]       state;
    logic [1:0]       state_nxt;
    logic [DIV_W-1:0] div_cnt;
    logic             en_q;      // enable seen on the previous clock
    logic             enable;
    logic             last_cnt;

    assign enable      = run & ~bop;
    assign phase_valid = en_q & enable;  // first clock after a start is spent reloading
    assign last_cnt    = (div_cnt == '0);

    always_comb begin
        case (state)
            clock_pkg::PH_W: state_nxt = clock_pkg::PH_X;
            clock_pkg::PH_X: state_nxt = clock_pkg::PH_Y;
            clock_pkg::PH_Y: state_nxt = clock_pkg::PH_Z;
            default:         state_nxt = clock_pkg::PH_W;
        endcase
    end

    // ====================================================================
    // divider and gray state
    // ====================================================================
    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            en_q    <= 1'b0;
            state   <= clock_pkg::PH_W;
            div_cnt <= '0;
        end else begin
            en_q <= enable;
            if (!phase_valid) begin
                state   <= clock_pkg::PH_W;  // parked at w while held
                div_cnt <= divide;
            end else if (last_cnt) begin
                state   <= state_nxt;
                div_cnt <= divide;
            end else begin
                div_cnt <= div_cnt - 1'b1;
            end
        end
    end

    assign cgpp  = state[1];
    assign cgppn = ~state[1];
    assign cgqp  = state[0];
    assign cgqpn = ~state[0];
    assign cgrp  = phase_valid & last_cnt;  // last count of this phase step
    assign cgrpn = ~cgrp;

    a_gray_step: assert property (
        @(posedge sim_clk) disable iff (!arst_n)
        (phase_valid && cgrp) |=> ($countones(state ^ $past(state)) == 1)
    );

endmodule

// ==== src/phase_drivers.sv ====
`timescale 1ns/1ps

module phase_drivers #(
    parameter int TAPS = 8
) (
    input  logic            sim_clk,
    input  logic            arst_n,
    input  logic            cgpp,
    input  logic            cgppn,
    input  logic            cgqp,
    input  logic            cgqpn,
    input  logic            cgrp,
    input  logic            cgrpn,
    input  logic            phase_valid,
    output logic [TAPS-1:0] w_taps,
    output logic [TAPS-1:0] x_taps,
    output logic [TAPS-1:0] y_taps,
    output logic [TAPS-1:0] z_taps,
    output logic            wda,
    output logic            xda,
    output logic            yda,
    output logic            zda,
    output logic            wn,
    output logic            xn,
    output logic            yn,
    output logic            zn,
    output logic            wf,
    output logic            xf,
    output logic            yf,
    output logic            zf
);

    logic w_lvl, x_lvl, y_lvl, z_lvl;
    logic w_last, x_last, y_last, z_last;
    logic w_set, x_set, y_set, z_set;

    // ====================================================================
    // set terms
    // ====================================================================
    assign w_lvl = cgppn & cgqpn;
    assign x_lvl = cgppn & cgqp;
    assign y_lvl = cgpp & cgqp;
    assign z_lvl = cgpp & cgqpn;

    assign w_last = w_lvl & cgrp;  // phase in its final count
    assign x_last = x_lvl & cgrp;
    assign y_last = y_lvl & cgrp;
    assign z_last = z_lvl & cgrp;

    // each phase is blocked while its predecessor is still finishing
    assign w_set = phase_valid & ((w_lvl & cgrpn) | w_last) & ~z_last;
    assign x_set = phase_valid & ((x_lvl & cgrpn) | x_last) & ~w_last;
    assign y_set = phase_valid & ((y_lvl & cgrpn) | y_last) & ~x_last;
    assign z_set = phase_valid & ((z_lvl & cgrpn) | z_last) & ~y_last;

    // early copies lead the flags by one clock
    assign wda = w_set;
    assign xda = x_set;
    assign yda = y_set;
    assign zda = z_set;

    // ====================================================================
    // phase flags
    // ====================================================================
    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            wf <= 1'b0;
            xf <= 1'b0;
            yf <= 1'b0;
            zf <= 1'b0;
        end else begin
            wf <= w_set;
            xf <= x_set;
            yf <= y_set;
            zf <= z_set;
        end
    end

    assign w_taps = {TAPS{wf}};  // fan-out
    assign x_taps = {TAPS{xf}};
    assign y_taps = {TAPS{yf}};
    assign z_taps = {TAPS{zf}};

    assign wn = ~wf;
    assign xn = ~xf;
    assign yn = ~yf;
    assign zn = ~zf;

    a_one_phase: assert property (
        @(posedge sim_clk) disable iff (!arst_n)
        $onehot0({wf, xf, yf, zf})
    );

endmodule

// ==== src/cycle_monitor.sv ====
`timescale 1ns/1ps

module cycle_monitor (
    input  logic                        sim_clk,
    input  logic                        arst_n,
    input  logic                        wf,
    input  logic                        xf,
    input  logic                        yf,
    input  logic                        zf,
    input  logic                        cnt_clear,
    output logic [clock_pkg::CNT_W-1:0] cycle_count,
    output logic                        overlap_err
);

    logic prev_wf;
    logic prev_zf;
    logic z_to_w;
    logic multi_hot;

    // ====================================================================
    // transition and overlap detect
    // ====================================================================
    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            prev_wf <= 1'b0;
            prev_zf <= 1'b0;
        end else begin
            prev_wf <= wf;
            prev_zf <= zf;
        end
    end

    // first clock of w after z
    assign z_to_w = wf & ~prev_wf & prev_zf;

    assign multi_hot = (wf & xf) | (wf & yf) | (wf & zf)
                     | (xf & yf) | (xf & zf) | (yf & zf);

    // ====================================================================
    // counters
    // ====================================================================
    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            cycle_count <= '0;
        end else if (cnt_clear) begin
            cycle_count <= '0;
        end else if (z_to_w) begin
            cycle_count <= cycle_count + 1'b1;  // wraps at 128
        end
    end

    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            overlap_err <= 1'b0;
        end else if (cnt_clear) begin
            overlap_err <= 1'b0;
        end else if (multi_hot) begin
            overlap_err <= 1'b1;  // sticky
        end
    end

endmodule

// ==== src/clock_subsystem.sv ====
`timescale 1ns/1ps

module clock_subsystem #(
    parameter int TAPS  = 8,
    parameter int DIV_W = 4
) (
    input  logic                         sim_clk,
    input  logic                         arst_n,
    input  logic                         cfg_we,
    input  logic [clock_pkg::ADDR_W-1:0] cfg_addr,
    input  logic [clock_pkg::DATA_W-1:0] cfg_wdata,
    output logic [clock_pkg::DATA_W-1:0] cfg_rdata,
    output logic [TAPS-1:0]              w_taps,
    output logic [TAPS-1:0]              x_taps,
    output logic [TAPS-1:0]              y_taps,
    output logic [TAPS-1:0]              z_taps,
    output logic                         wda,
    output logic                         xda,
    output logic                         yda,
    output logic                         zda,
    output logic                         wn,
    output logic                         xn,
    output logic                         yn,
    output logic                         zn
);

    logic                        run;
    logic                        bop;
    logic [DIV_W-1:0]            divide;
    logic                        cnt_clear;
    logic [clock_pkg::CNT_W-1:0] cycle_count;
    logic                        overlap_err;
    logic                        cgpp, cgppn, cgqp, cgqpn, cgrp, cgrpn;
    logic                        phase_valid;
    logic                        wf, xf, yf, zf;

    // ====================================================================
    // configuration and timing chain
    // ====================================================================
    clock_config #(.DIV_W(DIV_W)) u_config (
        .sim_clk    (sim_clk),
        .arst_n     (arst_n),
        .cfg_we     (cfg_we),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cycle_count(cycle_count),
        .overlap_err(overlap_err),
        .cfg_rdata  (cfg_rdata),
        .run        (run),
        .bop        (bop),
        .divide     (divide),
        .cnt_clear  (cnt_clear)
    );

    phase_counter #(.DIV_W(DIV_W)) u_counter (
        .sim_clk    (sim_clk),
        .arst_n     (arst_n),
        .run        (run),
        .bop        (bop),
        .divide     (divide),
        .cgpp       (cgpp),
        .cgppn      (cgppn),
        .cgqp       (cgqp),
        .cgqpn      (cgqpn),
        .cgrp       (cgrp),
        .cgrpn      (cgrpn),
        .phase_valid(phase_valid)
    );

    phase_drivers #(.TAPS(TAPS)) u_drivers (
        .sim_clk(sim_clk), .arst_n(arst_n),
        .cgpp(cgpp), .cgppn(cgppn), .cgqp(cgqp), .cgqpn(cgqpn),
        .cgrp(cgrp), .cgrpn(cgrpn), .phase_valid(phase_valid),
        .w_taps(w_taps), .x_taps(x_taps), .y_taps(y_taps), .z_taps(z_taps),
        .wda(wda), .xda(xda), .yda(yda), .zda(zda),
        .wn(wn), .xn(xn), .yn(yn), .zn(zn),
        .wf(wf), .xf(xf), .yf(yf), .zf(zf)
    );

    cycle_monitor u_monitor (
        .sim_clk    (sim_clk),
        .arst_n     (arst_n),
        .wf         (wf),
        .xf         (xf),
        .yf         (yf),
        .zf         (zf),
        .cnt_clear  (cnt_clear),
        .cycle_count(cycle_count),
        .overlap_err(overlap_err)
    );

endmodule

// ==== testbench/clock_subsystem_tb.sv ====
`timescale 1ns/1ps

module clock_subsystem_tb;

    localparam int TAPS   = 8;
    localparam int DIV_W  = 4;
    localparam int PERIOD = 40;
    localparam int NROWS  = 5;

    logic                         sim_clk;
    logic                         arst_n;
    logic                         cfg_we;
    logic [clock_pkg::ADDR_W-1:0] cfg_addr;
    logic [clock_pkg::DATA_W-1:0] cfg_wdata;
    logic [clock_pkg::DATA_W-1:0] cfg_rdata;
    logic [TAPS-1:0]              w_taps, x_taps, y_taps, z_taps;
    logic                         wda, xda, yda, zda;
    logic                         wn, xn, yn, zn;

    // ====================================================================
    // stimulus table of divide, major cycles, bop pulse and final count
    // ====================================================================
    int row_div    [NROWS] = '{0, 1, 3, 7, 0};
    int row_cycles [NROWS] = '{130, 3, 2, 1, 2};
    int row_bop    [NROWS] = '{0, 1, 0, 1, 0};
    int row_count  [NROWS] = '{2, 4, 2, 2, 2};  // (cycles + bop) mod 128

    int errors       = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int cycle_cnt    = 0;
    int cycle_limit  = 0;

    clock_subsystem #(.TAPS(TAPS), .DIV_W(DIV_W)) UUT (
        .sim_clk  (sim_clk),
        .arst_n   (arst_n),
        .cfg_we   (cfg_we),
        .cfg_addr (cfg_addr),
        .cfg_wdata(cfg_wdata),
        .cfg_rdata(cfg_rdata),
        .w_taps   (w_taps),
        .x_taps   (x_taps),
        .y_taps   (y_taps),
        .z_taps   (z_taps),
        .wda      (wda),
        .xda      (xda),
        .yda      (yda),
        .zda      (zda),
        .wn       (wn),
        .xn       (xn),
        .yn       (yn),
        .zn       (zn)
    );

    initial begin
        sim_clk = 1'b0;
        forever #(PERIOD/2) sim_clk = ~sim_clk;
    end

    always @(posedge sim_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic report_mismatch(input string msg);
        errors++;
        $display("Mismatch at %0t: %s", $time, msg);
    endtask

    // one-hot {z,y,x,w} to phase index with -1 for none and -2 for overlap
    function automatic int phase_code(input logic [3:0] v);
        case (v)
            4'b0000: return -1;
            4'b0001: return 0;
            4'b0010: return 1;
            4'b0100: return 2;
            4'b1000: return 3;
            default: return -2;
        endcase
    endfunction

    // taps rise 2 clocks after the run write and each phase is divide+1 long
    function automatic int expected_phase(input int k, input int div);
        if (k < 2) begin
            return -1;
        end
        return ((k - 2) / (div + 1)) % 4;
    endfunction

    // called on a falling edge and returns on the next one
    task automatic write_reg(input logic [clock_pkg::ADDR_W-1:0] addr, input logic [7:0] data);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge sim_clk);
        cfg_we    = 1'b0;
    endtask

    task automatic expect_reg(input logic [clock_pkg::ADDR_W-1:0] addr,
                              input logic [7:0] exp, input string what);
        logic [7:0] data;
        cfg_addr = addr;
        #(PERIOD/4);
        data = cfg_rdata;  // readback is combinational
        if (data !== exp) begin
            report_mismatch($sformatf("%s read 0x%02h, expected 0x%02h", what, data, exp));
        end
        @(negedge sim_clk);
    endtask

    task automatic check_sample(input int exp_tap, input int exp_da, input int k);
        int got_tap;
        int got_da;
        got_tap = phase_code({z_taps[0], y_taps[0], x_taps[0], w_taps[0]});
        got_da  = phase_code({zda, yda, xda, wda});
        if (got_tap != exp_tap) begin
            report_mismatch($sformatf("clock %0d tap phase %0d, expected %0d",
                                      k, got_tap, exp_tap));
        end
        if (got_da != exp_da) begin
            report_mismatch($sformatf("clock %0d da phase %0d, expected %0d",
                                      k, got_da, exp_da));
        end
        if (w_taps !== {TAPS{w_taps[0]}} || x_taps !== {TAPS{x_taps[0]}} ||
            y_taps !== {TAPS{y_taps[0]}} || z_taps !== {TAPS{z_taps[0]}}) begin
            report_mismatch($sformatf("clock %0d taps of one phase differ", k));
        end
        if ({wn, xn, yn, zn} !== ~{w_taps[0], x_taps[0], y_taps[0], z_taps[0]}) begin
            report_mismatch($sformatf("clock %0d n outputs not inverse of taps", k));
        end
    endtask

    // ====================================================================
    // run from the start write through a number of major cycles
    // ====================================================================
    task automatic measure_phases(input int div, input int cycles);
        int last_k;
        int cur;
        int prev;
        int len;
        int first_rise;
        last_k     = 2 + 4 * (div + 1) * cycles + 1;  // one clock past the last z-to-w
        prev       = -1;
        len        = 0;
        first_rise = -1;
        write_reg(clock_pkg::ADDR_CTRL, 8'h01);
        for (int k = 0; k <= last_k; k++) begin
            if (k > 0) begin
                @(negedge sim_clk);
            end
            check_sample(expected_phase(k, div), expected_phase(k + 1, div), k);
            cur = phase_code({z_taps[0], y_taps[0], x_taps[0], w_taps[0]});
            if (cur == 0 && first_rise < 0) begin
                first_rise = k;
            end
            if (cur != prev) begin
                if (prev >= 0 && len != div + 1) begin
                    report_mismatch($sformatf("phase %0d lasted %0d clocks, expected %0d",
                                              prev, len, div + 1));
                end
                len = 0;
            end
            len++;
            prev = cur;
        end
        if (first_rise != 2) begin
            report_mismatch($sformatf("first w rise after %0d clocks, expected 2", first_rise));
        end
    endtask

    // entered on the sample right after the stopping write
    task automatic verify_drop(input string what);
        if (phase_code({z_taps[0], y_taps[0], x_taps[0], w_taps[0]}) < 0) begin
            report_mismatch($sformatf("phases gone at the %s write edge", what));
        end
        if (phase_code({zda, yda, xda, wda}) != -1) begin
            report_mismatch($sformatf("early copies still high after %s", what));
        end
        repeat (3) begin
            @(negedge sim_clk);
            check_sample(-1, -1, 0);
        end
    endtask

    task automatic close_test(input string name, input int err_start);
        if (errors == err_start) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_start);
        end
    endtask

    // ====================================================================
    // main sequence
    // ====================================================================
    initial begin
        int err_start;
        void'($urandom(11906));
        row_div[4] = $urandom % 16;
        for (int r = 0; r < NROWS; r++) begin
            cycle_limit += 4 * (row_div[r] + 1) * (row_cycles[r] + row_bop[r]) + 50;
        end

        arst_n    = 1'b0;
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        repeat (3) @(posedge sim_clk);
        @(negedge sim_clk);
        arst_n = 1'b1;

        err_start = errors;
        check_sample(-1, -1, 0);
        expect_reg(clock_pkg::ADDR_CTRL, 8'h00, "control after reset");
        expect_reg(clock_pkg::ADDR_DIVIDE, 8'h00, "divide after reset");
        expect_reg(clock_pkg::ADDR_STATUS, 8'h00, "status after reset");
        close_test("reset", err_start);

        for (int r = 0; r < NROWS; r++) begin
            err_start = errors;
            write_reg(clock_pkg::ADDR_DIVIDE, row_div[r]);
            expect_reg(clock_pkg::ADDR_DIVIDE, row_div[r], "divide readback");
            write_reg(clock_pkg::ADDR_STATUS, 8'h00);  // clears count and error
            expect_reg(clock_pkg::ADDR_STATUS, 8'h00, "status after clear");
            measure_phases(row_div[r], row_cycles[r]);
            if (row_bop[r] != 0) begin
                expect_reg(clock_pkg::ADDR_STATUS, row_cycles[r] % 128, "count before hold");
                write_reg(clock_pkg::ADDR_CTRL, 8'h03);
                verify_drop("bop");
                expect_reg(clock_pkg::ADDR_CTRL, 8'h03, "control during hold");
                expect_reg(clock_pkg::ADDR_STATUS, row_cycles[r] % 128, "count during hold");
                measure_phases(row_div[r], 1);
            end
            expect_reg(clock_pkg::ADDR_STATUS, row_count[r], "major-cycle count");
            write_reg(clock_pkg::ADDR_CTRL, 8'h00);
            verify_drop("run=0");
            expect_reg(clock_pkg::ADDR_CTRL, 8'h00, "control after stop");
            close_test($sformatf("row %0d divide %0d", r, row_div[r]), err_start);
        end

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== build.f ====
src/clock_pkg.sv
src/clock_config.sv
src/phase_counter.sv
src/phase_drivers.sv
src/cycle_monitor.sv
src/clock_subsystem.sv
testbench/clock_subsystem_tb.sv
